// ==== verilog/usbPkg.sv ====
////////////////////
// shared types and line constants for the full-speed USB board front end
// every RTL module imports what it needs from here
// the testbench assertions use the same names
////////////////////
package usbPkg;

  ////////////////////
  // line state

  // sampled bus with D+ in the upper bit and D- in the lower bit
  typedef logic [1:0] lineState_t;

  // idle state of a full-speed bus
  localparam lineState_t lineJ   = 2'b10;
  localparam lineState_t lineK   = 2'b01;
  // both lines low
  localparam lineState_t lineSe0 = 2'b00;

  ////////////////////
  // counters

  // run length in clk cycles
  // wide enough for 100 ms at 48 MHz
  typedef logic [23:0] count_t;

  ////////////////////
  // attach FSM

  typedef enum logic [1:0] {
    detached,
    // vbus seen and being qualified
    debouncing,
    attached
  } attachState_t;

endpackage

// ==== verilog/lockReset.sv ====
////////////////////
// internal reset for the USB front end
// asserts at once on board reset or on PLL loss of lock
// releases on the 2nd clk edge after both are good
// all other blocks take rst as their async reset
////////////////////
`timescale 1ns/1ns

module lockReset (
  input  logic clk,
  input  logic arstN,
  input  logic pllLocked,
  output logic rst
);

  // low while either reset source is bad
  logic       lockArstN;
  // release chain
  logic [1:0] rstSync;

  assign lockArstN = arstN & pllLocked;

  // assert asynchronously and shift zeros in once clear
  always_ff @(posedge clk or negedge lockArstN) begin
    if (!lockArstN) begin
      rstSync <= 2'b11;
    end else begin
      rstSync <= {rstSync[0], 1'b0};
    end
  end

  // second flop drives the cores
  assign rst = rstSync[1];

endmodule

// ==== verilog/lineReceiver.sv ====
////////////////////
// USB line receiver
// double-syncs the single-ended D+ and D- pins
// reports the line state and times SE0 and idle runs
// gives one bus-reset pulse per long SE0 and a suspend level
////////////////////
`timescale 1ns/1ns

module lineReceiver #(
  parameter usbPkg::count_t resetCycles   = usbPkg::count_t'(120),
  parameter usbPkg::count_t suspendCycles = usbPkg::count_t'(144000)
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               vp,
  input  logic               vm,
  output usbPkg::lineState_t lineState,
  output logic               seReset,
  output logic               suspend
);

  import usbPkg::*;

  // first sync stage
  logic       vpMeta;
  logic       vmMeta;
  // value lineState takes on the next edge
  lineState_t lineNext;
  // cycles the current line value has been held
  count_t     runCount;
  logic       lineChange;
  logic       runMax;

  ////////////////////
  // pin sync

  assign lineNext = {vpMeta, vmMeta};

  // two flops per pin
  // reset value reads as SE0
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vpMeta    <= 1'b0;
      vmMeta    <= 1'b0;
      lineState <= lineSe0;
    end else begin
      vpMeta    <= vp;
      vmMeta    <= vm;
      lineState <= lineNext;
    end
  end

  ////////////////////
  // run counter

  // class change seen one stage ahead
  // so the count lines up with lineState
  assign lineChange = (lineNext != lineState);
  assign runMax     = (runCount == '1);

  // restart at one on a change
  // saturate on very long runs
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      runCount <= '0;
    end else if (lineChange) begin
      runCount <= count_t'(1);
    end else if (!runMax) begin
      runCount <= runCount + count_t'(1);
    end
  end

  ////////////////////
  // decode

  // single pulse when the SE0 run hits the reset length
  // equality only so a longer run does not repeat it
  assign seReset = (lineState == lineSe0) && (runCount == resetCycles);

  // idle J long enough means suspend
  // drops on the first non-J cycle since the class check fails at once
  assign suspend = (lineState == lineJ) && (runCount >= suspendCycles);

endmodule

// ==== verilog/attachControl.sv ====
////////////////////
// VBUS attach control
// debounces the VBUS detect pin before raising the D+ pull-up
// drops the pull-up as soon as VBUS goes away
// passes line bus resets on only while attached
////////////////////
`timescale 1ns/1ns

module attachControl #(
  parameter usbPkg::count_t attachCycles = usbPkg::count_t'(4800000)
) (
  input  logic clk,
  input  logic rst,
  input  logic vBusDetect,
  input  logic seReset,
  output logic dPlusPullup,
  output logic attached,
  output logic busReset
);

  import usbPkg::*;

  // vbus sync stages
  logic         vBusMeta;
  logic         vBusSync;
  attachState_t state;
  attachState_t stateNext;
  // debouncing cycles so far including the current one
  count_t       debounceCount;
  count_t       debounceNext;
  // high exactly in the attached state
  logic         pullupReg;

  // vbus comes from a slow comparator so sync it first
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vBusMeta <= 1'b0;
      vBusSync <= 1'b0;
    end else begin
      vBusMeta <= vBusDetect;
      vBusSync <= vBusMeta;
    end
  end

  ////////////////////
  // attach FSM

  // the port named attached hides the enum value so that one is scoped
  always_comb begin
    stateNext    = state;
    debounceNext = debounceCount;
    case (state)
      detached: begin
        debounceNext = '0;
        if (vBusSync) begin
          stateNext    = debouncing;
          debounceNext = count_t'(1);
        end
      end
      debouncing: begin
        if (!vBusSync) begin
          // glitch or bounce
          stateNext    = detached;
          debounceNext = '0;
        end else if (debounceCount >= attachCycles) begin
          stateNext    = usbPkg::attached;
          debounceNext = '0;
        end else begin
          debounceNext = debounceCount + count_t'(1);
        end
      end
      usbPkg::attached: begin
        // no debounce on the way out
        if (!vBusSync) begin
          stateNext = detached;
        end
      end
      default: begin
        stateNext    = detached;
        debounceNext = '0;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state         <= detached;
      debounceCount <= '0;
      pullupReg     <= 1'b0;
      busReset      <= 1'b0;
    end else begin
      state         <= stateNext;
      debounceCount <= debounceNext;
      // registered from next state so it tracks state with no decode glitch
      pullupReg     <= (stateNext == usbPkg::attached);
      // detached device ignores bus resets
      busReset      <= seReset && (state == usbPkg::attached);
    end
  end

  assign dPlusPullup = pullupReg;
  assign attached    = pullupReg;

endmodule

// ==== verilog/usbBoardTop.sv ====
////////////////////
// board top level of the full-speed USB device front end
// maps the clock and PLL lock and USB pins onto the device logic
// timing parameters are in 48 MHz cycles and passed down from here
////////////////////
`timescale 1ns/1ns

module usbBoardTop #(
  // 2.5 us of SE0
  parameter usbPkg::count_t resetCycles   = usbPkg::count_t'(120),
  // 3 ms of idle
  parameter usbPkg::count_t suspendCycles = usbPkg::count_t'(144000),
  // 100 ms of steady vbus
  parameter usbPkg::count_t attachCycles  = usbPkg::count_t'(4800000)
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               pllLocked,
  // single-ended receiver outputs of the PHY
  input  logic               vp,
  input  logic               vm,
  input  logic               vBusDetect,
  output usbPkg::lineState_t lineState,
  output logic               busReset,
  output logic               suspend,
  output logic               dPlusPullup,
  output logic               attached
);

  // internal active-high reset
  logic rst;
  // raw bus reset from the line before the attach gate
  logic seReset;

  ////////////////////
  // reset

  lockReset uLockReset (
    .clk       (clk),
    .arstN     (arstN),
    .pllLocked (pllLocked),
    .rst       (rst)
  );

  ////////////////////
  // line and attach

  lineReceiver #(
    .resetCycles   (resetCycles),
    .suspendCycles (suspendCycles)
  ) uLineReceiver (
    .clk       (clk),
    .rst       (rst),
    .vp        (vp),
    .vm        (vm),
    .lineState (lineState),
    .seReset   (seReset),
    .suspend   (suspend)
  );

  // pull-up goes straight out to the D+ pin driver
  attachControl #(
    .attachCycles (attachCycles)
  ) uAttachControl (
    .clk         (clk),
    .rst         (rst),
    .vBusDetect  (vBusDetect),
    .seReset     (seReset),
    .dPlusPullup (dPlusPullup),
    .attached    (attached),
    .busReset    (busReset)
  );

endmodule

// ==== tests/usbBoardTb_assert.sv ====
////////////////////
// concurrent checks for the USB board front end
// bound into usbBoardTop, expected values come from pin history
// every check ends in recordFail when it fails
////////////////////
`timescale 1ns/1ns

module usbBoardTb_assert #(
  parameter usbPkg::count_t resetCycles   = usbPkg::count_t'(8),
  parameter usbPkg::count_t suspendCycles = usbPkg::count_t'(20),
  parameter usbPkg::count_t attachCycles  = usbPkg::count_t'(10)
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 arstN,
  input logic                 pllLocked,
  input logic                 vp,
  input logic                 vm,
  input logic                 vBusDetect,
  input usbPkg::lineState_t   lineState,
  input logic                 busReset,
  input logic                 suspend,
  input logic                 dPlusPullup,
  input logic                 attached,
  input usbPkg::attachState_t fsmState
);

  import usbPkg::*;

  localparam int resetLen   = int'(resetCycles);
  localparam int suspendLen = int'(suspendCycles);
  localparam int attachLen  = int'(attachCycles);

  int failCount = 0;
  // runs at the pins, each ending on the previous tick
  int vbusRun   = 0;
  int se0Run    = 0;
  int jRun      = 0;

  task automatic recordFail(input string msg);
    failCount = failCount + 1;
    $error("%s", msg);
  endtask

  always @(posedge clk) begin
    vbusRun <= vBusDetect ? vbusRun + 1 : 0;
    se0Run  <= ({vp, vm} == lineSe0) ? se0Run + 1 : 0;
    jRun    <= ({vp, vm} == lineJ) ? jRun + 1 : 0;
  end

  ////////////////////
  // reset and attach

  quietInReset: assert property (@(posedge clk) (!arstN || !pllLocked) |->
    !busReset && !suspend && !dPlusPullup && !attached)
    else recordFail("control output high during reset or before lock");

  // attach FSM sits in attached only behind a full vbus run
  stateFollowsVbus: assert property (@(posedge clk) disable iff (rst)
    (fsmState == usbPkg::attached) == ($past(vbusRun, 2) > attachLen))
    else recordFail("attach state does not follow the debounced vbus");

  // 2 sync stages plus the output flop
  detachDropsPullup: assert property (@(posedge clk) disable iff (rst)
    !$past(vBusDetect, 3) |-> !dPlusPullup && !attached)
    else recordFail("pull-up still on after vbus went away");

  attachNotEarly: assert property (@(posedge clk) disable iff (rst)
    $rose(dPlusPullup) || $rose(attached) |-> $past(vbusRun, 2) == attachLen + 1)
    else recordFail("pull-up rose without a full debounce");

  attachOnTime: assert property (@(posedge clk) disable iff (rst)
    $past(vbusRun, 2) == attachLen + 1 |-> $rose(dPlusPullup) && $rose(attached))
    else recordFail("pull-up missed its rise after steady vbus");

  ////////////////////
  // line checks

  // lineState sits at SE0 for two ticks after release
  lineDelay: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) && !$past(rst, 2) |-> lineState == $past({vp, vm}, 2))
    else recordFail("lineState does not match the pins two cycles back");

  // pulse exactly resetCycles + 2 after the SE0 starts, attached only
  busResetTiming: assert property (@(posedge clk) disable iff (rst)
    busReset == ($past(se0Run, 2) == resetLen && $past(vbusRun, 3) > attachLen))
    else recordFail("bus reset pulse missing, extra or mistimed");

  suspendTiming: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) && !$past(rst, 2) |-> suspend == ($past(jRun) >= suspendLen))
    else recordFail("suspend level does not follow the idle J run");

endmodule

bind usbBoardTop usbBoardTb_assert #(
  .resetCycles   (resetCycles),
  .suspendCycles (suspendCycles),
  .attachCycles  (attachCycles)
) uAssert (
  .clk         (clk),
  .rst         (rst),
  .arstN       (arstN),
  .pllLocked   (pllLocked),
  .vp          (vp),
  .vm          (vm),
  .vBusDetect  (vBusDetect),
  .lineState   (lineState),
  .busReset    (busReset),
  .suspend     (suspend),
  .dPlusPullup (dPlusPullup),
  .attached    (attached),
  .fsmState    (uAttachControl.state)
);

// ==== tests/usbBoardTb.sv ====
////////////////////
// testbench for the USB board front end
// drives reset, lock, line runs and vbus steps
// checking is done by the bound assertion module
////////////////////
`timescale 1ns/1ns

module usbBoardTb;

  import usbPkg::*;

  // stimulus is about 700 cycles, so plenty of margin
  localparam int timeoutCycles = 3000;

  logic        clk;
  logic        arstN;
  logic        pllLocked;
  logic        vp;
  logic        vm;
  logic        vBusDetect;
  lineState_t  lineState;
  logic        busReset;
  logic        suspend;
  logic        dPlusPullup;
  logic        attached;
  logic [31:0] lcgState;
  int          cycleCount = 0;

  usbBoardTop #(
    .resetCycles   (count_t'(8)),
    .suspendCycles (count_t'(20)),
    .attachCycles  (count_t'(10))
  ) DUT (
    .clk         (clk),
    .arstN       (arstN),
    .pllLocked   (pllLocked),
    .vp          (vp),
    .vm          (vm),
    .vBusDetect  (vBusDetect),
    .lineState   (lineState),
    .busReset    (busReset),
    .suspend     (suspend),
    .dPlusPullup (dPlusPullup),
    .attached    (attached)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // helpers

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int pickLength(input int lo, input int hi);
    logic [31:0] r;
    r = nextRand();
    return lo + int'(r[23:8]) % (hi - lo + 1);
  endfunction

  task automatic driveLine(input lineState_t value, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      vp <= value[1];
      vm <= value[0];
    end
  endtask

  task automatic holdVbus(input logic level, input int cycles);
    @(posedge clk);
    vBusDetect <= level;
    repeat (cycles - 1) @(posedge clk);
  endtask

  // block until the pull-up reaches the given level
  task automatic waitPullup(input logic level);
    while (dPlusPullup !== level) @(posedge clk);
  endtask

  // short K, random SE0, random idle
  task automatic lineBurst();
    driveLine(lineK, pickLength(1, 4));
    driveLine(lineSe0, pickLength(3, 14));
    driveLine(lineJ, pickLength(5, 30));
  endtask

  ////////////////////
  // watchers

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("sim failed");
      $fatal(1, "stopped by the cycle limit");
    end
  end

  always @(posedge clk) begin
    if (DUT.uAssert.failCount != 0) begin
      $display("ERR %0t: assertion check failed", $time);
      $display("sim failed");
      $fatal(1, "stopped at the first assertion failure");
    end
  end

  ////////////////////
  // stimulus

  initial begin
    arstN      <= 1'b0;
    pllLocked  <= 1'b0;
    vp         <= 1'b0;
    vm         <= 1'b0;
    vBusDetect <= 1'b0;
    lcgState   = 32'h8e63_a2be;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    repeat (3) @(posedge clk);
    pllLocked <= 1'b1;
    // line stays SE0 until the release is done
    repeat (4) @(posedge clk);
    // detached traffic gives no bus reset
    driveLine(lineJ, 10);
    repeat (4) lineBurst();
    // vbus glitch shorter than the debounce
    holdVbus(1'b1, 5);
    holdVbus(1'b0, 12);
    holdVbus(1'b1, 1);
    waitPullup(1'b1);
    // suspend, then long and short SE0
    driveLine(lineJ, 40);
    driveLine(lineSe0, 12);
    driveLine(lineJ, 6);
    driveLine(lineSe0, 5);
    driveLine(lineJ, 6);
    repeat (12) lineBurst();
    // detach then a long SE0 that must be ignored
    holdVbus(1'b0, 1);
    waitPullup(1'b0);
    driveLine(lineSe0, 12);
    driveLine(lineJ, 10);
    // reattach
    holdVbus(1'b1, 1);
    waitPullup(1'b1);
    repeat (6) lineBurst();
    driveLine(lineJ, 10);
    // let the last checks settle
    repeat (2) @(posedge clk);
    if (DUT.uAssert.failCount == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("ERR %0t: %0d assertion failures", $time, DUT.uAssert.failCount);
      $display("sim failed");
      $fatal(1, "assertion failures at the end of the run");
    end
  end

endmodule

// ==== verilog.f ====
verilog/usbPkg.sv
verilog/lockReset.sv
verilog/lineReceiver.sv
verilog/attachControl.sv
verilog/usbBoardTop.sv
tests/usbBoardTb_assert.sv
tests/usbBoardTb.sv

// ==== Makefile ====
# Verilator flow for the USB board front end testbench
TOP = usbBoardTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

# pass only when the simulation output holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o usbBoardSim
	@out="$$(./obj_dir/usbBoardSim 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir
